// ==== rtl/core_settings.svh ====
// core settings
// data width, memory depth and reset values for the RV64I pipeline
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

`define XLEN 64
`define PC_START 64'h8000_0000
`define DMEM_WORDS 64
// addi x0, x0, 0
`define NOP_INST 32'h0000_0013

`endif

// ==== rtl/core_pkg.sv ====
// core types
// operation encoding and the payloads carried between pipeline stages
`default_nettype none
`include "core_settings.svh"

package core_pkg;

  typedef logic [`XLEN-1:0] word_t;
  typedef logic [4:0] reg_addr_t;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLL,
    ALU_SRL,
    ALU_LUI
  } alu_op_t;

  typedef struct packed {
    word_t       pc;
    logic [31:0] inst;
    alu_op_t     alu_op;
    logic        is_branch_eq;
    logic        is_branch_ne;
    logic        is_jal;
    logic        use_rs1;
    logic        use_rs2;
    reg_addr_t   rs1;
    reg_addr_t   rs2;
    word_t       rs1_data;
    word_t       rs2_data;
    word_t       imm;
    logic        mem_rd;
    logic        mem_wr;
    logic        reg_wr;
    reg_addr_t   rd;
  } id_ex_t;

  typedef struct packed {
    word_t       pc;
    logic [31:0] inst;
    word_t       alu_result;
    word_t       store_data;
    logic        mem_rd;
    logic        mem_wr;
    logic        reg_wr;
    reg_addr_t   rd;
  } ex_mem_t;

  typedef struct packed {
    word_t       pc;
    logic [31:0] inst;
    word_t       wdata;
    logic        reg_wr;
    reg_addr_t   rd;
  } mem_wb_t;

endpackage

`default_nettype wire

// ==== rtl/bypass_if.sv ====
// bypass bus
// register results of MEM and WB, seen by forwarding and hazard logic
`default_nettype none

interface bypass_if;
  import core_pkg::*;

  logic      mem_wr;
  reg_addr_t mem_rd_addr;
  word_t     mem_data;
  logic      mem_is_load;
  logic      wb_wr;
  reg_addr_t wb_rd_addr;
  word_t     wb_data;

  modport source (output mem_wr, mem_rd_addr, mem_data, mem_is_load,
                  output wb_wr, wb_rd_addr, wb_data);
  modport fwd (input mem_wr, mem_rd_addr, mem_data, mem_is_load,
               input wb_wr, wb_rd_addr, wb_data);
endinterface

`default_nettype wire

// ==== rtl/pipe_stage_reg.sv ====
// pipeline stage register
// one item plus valid bit, with valid/allowin flow control
`default_nettype none

module pipe_stage_reg #(
  parameter type payload_t = logic [31:0]
) (
  input  logic     clock,
  input  logic     reset,
  input  logic     flush,
  input  logic     in_valid,
  input  payload_t in_payload,
  input  logic     next_allowin,
  output logic     allowin,
  output logic     out_valid,
  output payload_t out_payload
);

  // empty, or the item moves on this cycle
  assign allowin = !out_valid || next_allowin;

  always_ff @(posedge clock) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else if (flush) begin
      out_valid <= 1'b0;
    end else if (allowin) begin
      out_valid <= in_valid;
    end
  end

  always_ff @(posedge clock) begin
    if (allowin) begin
      out_payload <= in_payload;
    end
  end

  a_valid_known: assert property (@(posedge clock) disable iff (reset)
    !$isunknown(out_valid));

endmodule

`default_nettype wire

// ==== rtl/regfile.sv ====
// integer register file
// 32 x 64, two read ports, write-first, x0 hard zero
`default_nettype none

module regfile (
  input  logic                clock,
  input  logic                reset,
  input  core_pkg::reg_addr_t rs1_addr,
  input  core_pkg::reg_addr_t rs2_addr,
  output core_pkg::word_t     rs1_data,
  output core_pkg::word_t     rs2_data,
  input  logic                wr_en,
  input  core_pkg::reg_addr_t wr_addr,
  input  core_pkg::word_t     wr_data
);
  import core_pkg::*;

  word_t regs [32];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en && wr_addr != '0) begin
      regs[wr_addr] <= wr_data;
    end
  end

  // bypass the write of this cycle
  assign rs1_data = (rs1_addr == '0) ? '0 :
                    (wr_en && wr_addr == rs1_addr) ? wr_data : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 :
                    (wr_en && wr_addr == rs2_addr) ? wr_data : regs[rs2_addr];

  a_no_x0_write: assert property (@(posedge clock) disable iff (reset)
    wr_en |-> wr_addr != '0);

endmodule

`default_nettype wire

// ==== rtl/decode_stage.sv ====
// instruction decode
// immediates, operand fetch and control flags for the ID/EX payload
`default_nettype none

module decode_stage (
  input  logic [31:0]         inst,
  input  core_pkg::word_t     pc,
  input  core_pkg::word_t     rs1_data,
  input  core_pkg::word_t     rs2_data,
  output core_pkg::reg_addr_t rs1_addr,
  output core_pkg::reg_addr_t rs2_addr,
  output core_pkg::id_ex_t    payload
);
  import core_pkg::*;

  localparam logic [6:0] OP_REG    = 7'b0110011;
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       legal;
  word_t      imm_i, imm_s, imm_b, imm_u, imm_j;

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];
  assign rs1_addr = inst[19:15];
  assign rs2_addr = inst[24:20];

  assign imm_i = {{52{inst[31]}}, inst[31:20]};
  assign imm_s = {{52{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{51{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u = {{32{inst[31]}}, inst[31:12], 12'b0};
  assign imm_j = {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb begin
    payload = '0;
    legal = 1'b1;
    payload.pc = pc;
    payload.inst = inst;
    payload.rs1 = rs1_addr;
    payload.rs2 = rs2_addr;
    payload.rs1_data = rs1_data;
    payload.rs2_data = rs2_data;
    payload.rd = inst[11:7];
    payload.alu_op = ALU_ADD;
    case (opcode)
      OP_REG: begin
        case ({funct7, funct3})
          {7'h00, 3'b000}: payload.alu_op = ALU_ADD;
          {7'h20, 3'b000}: payload.alu_op = ALU_SUB;
          {7'h00, 3'b001}: payload.alu_op = ALU_SLL;
          {7'h00, 3'b010}: payload.alu_op = ALU_SLT;
          {7'h00, 3'b100}: payload.alu_op = ALU_XOR;
          {7'h00, 3'b101}: payload.alu_op = ALU_SRL;
          {7'h00, 3'b110}: payload.alu_op = ALU_OR;
          {7'h00, 3'b111}: payload.alu_op = ALU_AND;
          default: legal = 1'b0;
        endcase
        payload.use_rs1 = legal;
        payload.use_rs2 = legal;
        payload.reg_wr = legal;
      end
      OP_IMM: begin
        case (funct3)
          3'b000: payload.alu_op = ALU_ADD;
          3'b100: payload.alu_op = ALU_XOR;
          3'b110: payload.alu_op = ALU_OR;
          3'b111: payload.alu_op = ALU_AND;
          default: legal = 1'b0;
        endcase
        payload.imm = imm_i;
        payload.use_rs1 = legal;
        payload.reg_wr = legal;
      end
      OP_LUI: begin
        payload.alu_op = ALU_LUI;
        payload.imm = imm_u;
        payload.reg_wr = 1'b1;
      end
      OP_BRANCH: begin
        payload.imm = imm_b;
        payload.is_branch_eq = (funct3 == 3'b000);
        payload.is_branch_ne = (funct3 == 3'b001);
        payload.use_rs1 = payload.is_branch_eq || payload.is_branch_ne;
        payload.use_rs2 = payload.use_rs1;
      end
      OP_JAL: begin
        payload.imm = imm_j;
        payload.is_jal = 1'b1;
        payload.reg_wr = 1'b1;
      end
      OP_LOAD: begin
        // ld only
        payload.imm = imm_i;
        payload.mem_rd = (funct3 == 3'b011);
        payload.use_rs1 = payload.mem_rd;
        payload.reg_wr = payload.mem_rd;
      end
      OP_STORE: begin
        payload.imm = imm_s;
        payload.mem_wr = (funct3 == 3'b011);
        payload.use_rs1 = payload.mem_wr;
        payload.use_rs2 = payload.mem_wr;
      end
      default: legal = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

// ==== rtl/execute_stage.sv ====
// execute stage
// operand forwarding, ALU and branch/jump resolution
`default_nettype none

module execute_stage (
  input  core_pkg::id_ex_t  payload,
  bypass_if.fwd             bp,
  output core_pkg::ex_mem_t result,
  output logic              redirect,
  output core_pkg::word_t   redirect_pc
);
  import core_pkg::*;

  word_t rs1_val, rs2_val;
  word_t op_b;
  word_t alu_out;
  logic  equal;

  // MEM wins over WB, x0 never forwarded
  always_comb begin
    rs1_val = payload.rs1_data;
    if (payload.rs1 != '0 && bp.wb_wr && bp.wb_rd_addr == payload.rs1) begin
      rs1_val = bp.wb_data;
    end
    if (payload.rs1 != '0 && bp.mem_wr && bp.mem_rd_addr == payload.rs1) begin
      rs1_val = bp.mem_data;
    end
    rs2_val = payload.rs2_data;
    if (payload.rs2 != '0 && bp.wb_wr && bp.wb_rd_addr == payload.rs2) begin
      rs2_val = bp.wb_data;
    end
    if (payload.rs2 != '0 && bp.mem_wr && bp.mem_rd_addr == payload.rs2) begin
      rs2_val = bp.mem_data;
    end
  end

  // stores use rs2 as data, the immediate for the address
  assign op_b = (payload.use_rs2 && !payload.mem_wr) ? rs2_val : payload.imm;

  always_comb begin
    case (payload.alu_op)
      ALU_SUB: alu_out = rs1_val - op_b;
      ALU_AND: alu_out = rs1_val & op_b;
      ALU_OR:  alu_out = rs1_val | op_b;
      ALU_XOR: alu_out = rs1_val ^ op_b;
      ALU_SLT: alu_out = word_t'($signed(rs1_val) < $signed(op_b));
      ALU_SLL: alu_out = rs1_val << op_b[5:0];
      ALU_SRL: alu_out = rs1_val >> op_b[5:0];
      ALU_LUI: alu_out = op_b;
      default: alu_out = rs1_val + op_b;
    endcase
  end

  assign equal = (rs1_val == rs2_val);
  // enables are zero on bubbles, so no valid term here
  assign redirect = (payload.is_branch_eq && equal) || (payload.is_branch_ne && !equal) ||
                    payload.is_jal;
  assign redirect_pc = payload.pc + payload.imm;

  always_comb begin
    result.pc = payload.pc;
    result.inst = payload.inst;
    result.alu_result = payload.is_jal ? payload.pc + 'd4 : alu_out;
    result.store_data = rs2_val;
    result.mem_rd = payload.mem_rd;
    result.mem_wr = payload.mem_wr;
    result.reg_wr = payload.reg_wr;
    result.rd = payload.rd;
  end

endmodule

`default_nettype wire

// ==== rtl/data_mem.sv ====
// data memory
// doubleword array for ld/sd, combinational read, write at clock edge
`default_nettype none
`include "core_settings.svh"

module data_mem (
  input  logic            clock,
  input  logic            reset,
  input  logic            rd_en,
  input  logic            wr_en,
  input  core_pkg::word_t addr,
  input  core_pkg::word_t wr_data,
  output core_pkg::word_t rd_data
);
  import core_pkg::*;

  localparam int IDX_W = $clog2(`DMEM_WORDS);

  word_t            mem [`DMEM_WORDS];
  logic [IDX_W-1:0] idx;

  assign idx = addr[IDX_W+2:3];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < `DMEM_WORDS; i++) begin
        mem[i] <= '0;
      end
    end else if (wr_en) begin
      mem[idx] <= wr_data;
    end
  end

  assign rd_data = rd_en ? mem[idx] : '0;

  a_aligned: assert property (@(posedge clock) disable iff (reset)
    (rd_en || wr_en) |-> addr[2:0] == 3'b000);

endmodule

`default_nettype wire

// ==== rtl/core_top.sv ====
// RV64I core top
// four-stage ID/EX/MEM/WB pipeline with forwarding and load-use stall
`default_nettype none
`include "core_settings.svh"

module core_top (
  input  logic                clock,
  input  logic                reset,
  output core_pkg::word_t     inst_addr,
  input  logic [31:0]         inst,
  output logic                commit_valid,
  output core_pkg::word_t     commit_pc,
  output logic [31:0]         commit_inst,
  output logic                commit_wen,
  output core_pkg::reg_addr_t commit_wdest,
  output core_pkg::word_t     commit_wdata
);
  import core_pkg::*;

  word_t       id_pc;
  logic        id_valid, id_allowin, id_go, stall;
  logic [31:0] id_inst;
  reg_addr_t   rs1_addr, rs2_addr;
  word_t       rs1_data, rs2_data;
  id_ex_t      dec_payload, id_item, ex_q;
  ex_mem_t     ex_result, mem_q;
  mem_wb_t     mem_item, wb_q;
  logic        ex_valid, ex_allowin, mem_valid, mem_allowin, wb_valid, wb_allowin;
  logic        redirect;
  word_t       redirect_pc;
  word_t       load_data;
  logic        rf_wen;

  bypass_if bp ();

  // PC lives in the ID register
  always_ff @(posedge clock) begin
    if (reset) begin
      id_valid <= 1'b0;
      id_pc <= `PC_START;
    end else if (redirect) begin
      id_valid <= 1'b1;
      id_pc <= redirect_pc;
    end else if (id_allowin) begin
      id_valid <= 1'b1;
      if (id_valid) begin
        id_pc <= id_pc + 'd4;
      end
    end
  end

  assign inst_addr = id_pc;
  // squashed slot decodes as a nop
  assign id_inst = redirect ? `NOP_INST : inst;

  regfile u_regfile (
    .clock(clock), .reset(reset),
    .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
    .rs1_data(rs1_data), .rs2_data(rs2_data),
    .wr_en(rf_wen), .wr_addr(wb_q.rd), .wr_data(wb_q.wdata)
  );

  decode_stage u_decode (
    .inst(id_inst), .pc(id_pc),
    .rs1_data(rs1_data), .rs2_data(rs2_data),
    .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
    .payload(dec_payload)
  );

  // load in EX feeding the instruction in ID
  assign stall = id_valid && ex_q.mem_rd && ex_q.rd != '0 &&
                 ((dec_payload.use_rs1 && rs1_addr == ex_q.rd) ||
                  (dec_payload.use_rs2 && rs2_addr == ex_q.rd));
  assign id_go = id_valid && !stall && !redirect;
  assign id_allowin = !id_valid || (!stall && ex_allowin);

  always_comb begin
    id_item = dec_payload;
    if (!id_go) begin
      id_item.use_rs1 = 1'b0;
      id_item.use_rs2 = 1'b0;
      id_item.is_branch_eq = 1'b0;
      id_item.is_branch_ne = 1'b0;
      id_item.is_jal = 1'b0;
      id_item.mem_rd = 1'b0;
      id_item.mem_wr = 1'b0;
      id_item.reg_wr = 1'b0;
    end
  end

  pipe_stage_reg #(.payload_t(id_ex_t)) u_id_ex (
    .clock(clock), .reset(reset), .flush(redirect),
    .in_valid(id_go), .in_payload(id_item), .next_allowin(mem_allowin),
    .allowin(ex_allowin), .out_valid(ex_valid), .out_payload(ex_q)
  );

  execute_stage u_execute (
    .payload(ex_q), .bp(bp), .result(ex_result),
    .redirect(redirect), .redirect_pc(redirect_pc)
  );

  pipe_stage_reg #(.payload_t(ex_mem_t)) u_ex_mem (
    .clock(clock), .reset(reset), .flush(1'b0),
    .in_valid(ex_valid), .in_payload(ex_result), .next_allowin(wb_allowin),
    .allowin(mem_allowin), .out_valid(mem_valid), .out_payload(mem_q)
  );

  data_mem u_data_mem (
    .clock(clock), .reset(reset),
    .rd_en(mem_valid && mem_q.mem_rd), .wr_en(mem_valid && mem_q.mem_wr),
    .addr(mem_q.alu_result), .wr_data(mem_q.store_data), .rd_data(load_data)
  );

  always_comb begin
    mem_item.pc = mem_q.pc;
    mem_item.inst = mem_q.inst;
    mem_item.wdata = mem_q.mem_rd ? load_data : mem_q.alu_result;
    mem_item.reg_wr = mem_q.reg_wr;
    mem_item.rd = mem_q.rd;
  end

  pipe_stage_reg #(.payload_t(mem_wb_t)) u_mem_wb (
    .clock(clock), .reset(reset), .flush(1'b0),
    .in_valid(mem_valid), .in_payload(mem_item), .next_allowin(1'b1),
    .allowin(wb_allowin), .out_valid(wb_valid), .out_payload(wb_q)
  );

  assign rf_wen = wb_valid && wb_q.reg_wr && wb_q.rd != '0;

  assign bp.mem_wr = mem_valid && mem_q.reg_wr && mem_q.rd != '0;
  assign bp.mem_rd_addr = mem_q.rd;
  assign bp.mem_data = mem_item.wdata;
  assign bp.mem_is_load = mem_valid && mem_q.mem_rd;
  assign bp.wb_wr = rf_wen;
  assign bp.wb_rd_addr = wb_q.rd;
  assign bp.wb_data = wb_q.wdata;

  assign commit_valid = wb_valid;
  assign commit_pc = wb_q.pc;
  assign commit_inst = wb_q.inst;
  assign commit_wen = rf_wen;
  assign commit_wdest = wb_q.rd;
  assign commit_wdata = wb_q.wdata;

  // the stall leaves a bubble, so no reader sits behind a load in MEM
  a_load_use_gap: assert property (@(posedge clock) disable iff (reset)
    bp.mem_is_load && bp.mem_wr |->
      !(ex_q.use_rs1 && ex_q.rs1 == bp.mem_rd_addr) &&
      !(ex_q.use_rs2 && ex_q.rs2 == bp.mem_rd_addr));

endmodule

`default_nettype wire

// ==== test/core_model.sv ====
// reference model
// random RV64I program generator and sequential instruction-level model
`default_nettype none
`include "core_settings.svh"

module core_model #(
  parameter int PROG_LEN = 300
);
  import core_pkg::*;

  localparam int ROM_WORDS = PROG_LEN + 16;
  // funct3 of addi, xori, ori, andi
  localparam logic [11:0] IMM_F3 = {3'b111, 3'b110, 3'b100, 3'b000};

  logic [31:0] rom [ROM_WORDS];
  word_t       exp_pc [PROG_LEN];
  logic [31:0] exp_inst [PROG_LEN];
  logic        exp_wen [PROG_LEN];
  reg_addr_t   exp_wdest [PROG_LEN];
  word_t       exp_wdata [PROG_LEN];
  int          exp_count;

  // instruction at addr, nop outside the program
  function automatic logic [31:0] fetch(input word_t addr);
    word_t offset;
    offset = addr - `PC_START;
    if (addr >= `PC_START && offset < 4 * ROM_WORDS && offset[1:0] == 2'b00) begin
      return rom[int'(offset >> 2)];
    end
    return `NOP_INST;
  endfunction

  task automatic build_program();
    int          i;
    int          kind;
    int          sel;
    reg_addr_t   rd, rs1, rs2;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [11:0] imm12, offs;
    logic [19:0] imm20;
    logic [12:0] boff;
    logic [20:0] joff;
    for (i = 0; i < ROM_WORDS; i++) begin
      rom[i] = `NOP_INST;
    end
    for (i = 0; i < PROG_LEN; i++) begin
      kind = $urandom % 16;
      // small register set for many dependencies
      rd = reg_addr_t'($urandom % 8);
      rs1 = reg_addr_t'($urandom % 8);
      rs2 = reg_addr_t'($urandom % 8);
      imm12 = 12'($urandom);
      imm20 = 20'($urandom);
      offs = 12'(($urandom % `DMEM_WORDS) * 8);
      boff = ($urandom % 2) ? 13'd12 : 13'd8;
      joff = ($urandom % 2) ? 21'd12 : 21'd8;
      if (kind < 6) begin
        f3 = 3'($urandom);
        f7 = (f3 == 3'b000 && ($urandom % 2)) ? 7'h20 : 7'h00;
        rom[i] = {f7, rs2, rs1, f3, rd, 7'b0110011};
      end else if (kind < 9) begin
        sel = $urandom % 4;
        f3 = IMM_F3[3 * sel +: 3];
        rom[i] = {imm12, rs1, f3, rd, 7'b0010011};
      end else if (kind == 9) begin
        rom[i] = {imm20, rd, 7'b0110111};
      end else if (kind < 12) begin
        rom[i] = {offs, 5'd0, 3'b011, rd, 7'b0000011};
      end else if (kind == 12) begin
        rom[i] = {offs[11:5], rs2, 5'd0, 3'b011, offs[4:0], 7'b0100011};
      end else if (kind < 15) begin
        f3 = ($urandom % 2) ? 3'b001 : 3'b000;
        rom[i] = {boff[12], boff[10:5], rs2, rs1, f3, boff[4:1], boff[11], 7'b1100011};
      end else begin
        rom[i] = {joff[20], joff[10:1], joff[11], joff[19:12], rd, 7'b1101111};
      end
    end
  endtask

  task automatic run_program();
    word_t       regs [32];
    word_t       dmem [`DMEM_WORDS];
    word_t       pc, next_pc, a, b, res, imm_i, addr;
    logic [31:0] w;
    logic        wen;
    int          idx;
    int          slot;
    for (idx = 0; idx < 32; idx++) begin
      regs[idx] = '0;
    end
    for (idx = 0; idx < `DMEM_WORDS; idx++) begin
      dmem[idx] = '0;
    end
    exp_count = 0;
    pc = `PC_START;
    idx = 0;
    while (idx < PROG_LEN) begin
      w = rom[idx];
      a = regs[w[19:15]];
      b = regs[w[24:20]];
      imm_i = {{52{w[31]}}, w[31:20]};
      res = '0;
      wen = 1'b0;
      next_pc = pc + 4;
      case (w[6:0])
        7'b0110011: begin
          wen = 1'b1;
          case ({w[30], w[14:12]})
            4'b0000: res = a + b;
            4'b1000: res = a - b;
            4'b0001: res = a << b[5:0];
            4'b0010: res = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
            4'b0100: res = a ^ b;
            4'b0101: res = a >> b[5:0];
            4'b0110: res = a | b;
            4'b0111: res = a & b;
            // sltu is not kept, so it retires as a no-op
            default: wen = 1'b0;
          endcase
        end
        7'b0010011: begin
          wen = 1'b1;
          case (w[14:12])
            3'b000: res = a + imm_i;
            3'b100: res = a ^ imm_i;
            3'b110: res = a | imm_i;
            default: res = a & imm_i;
          endcase
        end
        7'b0110111: begin
          wen = 1'b1;
          res = {{32{w[31]}}, w[31:12], 12'b0};
        end
        7'b0000011: begin
          wen = 1'b1;
          addr = a + imm_i;
          slot = int'((addr >> 3) % `DMEM_WORDS);
          res = dmem[slot];
        end
        7'b0100011: begin
          addr = a + {{52{w[31]}}, w[31:25], w[11:7]};
          slot = int'((addr >> 3) % `DMEM_WORDS);
          dmem[slot] = b;
        end
        7'b1100011: begin
          // beq on funct3 000, bne on 001
          if ((w[12] == 1'b0 && a == b) || (w[12] == 1'b1 && a != b)) begin
            next_pc = pc + {{51{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
          end
        end
        default: begin
          wen = 1'b1;
          res = pc + 4;
          next_pc = pc + {{43{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        end
      endcase
      wen = wen && w[11:7] != 5'd0;
      if (wen) begin
        regs[w[11:7]] = res;
      end
      exp_pc[exp_count] = pc;
      exp_inst[exp_count] = w;
      exp_wen[exp_count] = wen;
      exp_wdest[exp_count] = w[11:7];
      exp_wdata[exp_count] = res;
      exp_count++;
      pc = next_pc;
      idx = int'((pc - `PC_START) >> 2);
    end
  endtask

endmodule

`default_nettype wire

// ==== test/core_tb.sv ====
// core testbench
// runs a random program on the pipeline and checks every commit against the model
`default_nettype none
`include "core_settings.svh"

module core_tb;
  import core_pkg::*;

  localparam int SEED = 32'hf71c;
  localparam int PROG_LEN = 300;
  localparam int RESET_CYCLES = 16;
  localparam int CLOCK_PERIOD = 40;
  localparam int DRIVE_DELAY = 2;
  localparam int DRAIN_CYCLES = 8;
  localparam int TIMEOUT_CYCLES = 4 * PROG_LEN + RESET_CYCLES;

  logic        clock;
  logic        reset;
  word_t       inst_addr;
  logic [31:0] inst;
  logic        commit_valid;
  word_t       commit_pc;
  logic [31:0] commit_inst;
  logic        commit_wen;
  reg_addr_t   commit_wdest;
  word_t       commit_wdata;

  int errors;
  int next_commit;
  int cycle_count;

  core_model #(.PROG_LEN(PROG_LEN)) model ();

  core_top uut (
    .clock(clock), .reset(reset),
    .inst_addr(inst_addr), .inst(inst),
    .commit_valid(commit_valid), .commit_pc(commit_pc), .commit_inst(commit_inst),
    .commit_wen(commit_wen), .commit_wdest(commit_wdest), .commit_wdata(commit_wdata)
  );

  initial clock = 1'b0;
  always #(CLOCK_PERIOD / 2) clock = ~clock;

  task automatic check_value(input string name, input word_t expected, input word_t actual);
    assert (actual === expected) else begin
      $display("FAILED time %0t %s expected %h actual %h", $time, name, expected, actual);
      errors++;
    end
  endtask

  task automatic check_commit(input int k);
    check_value("commit_pc", model.exp_pc[k], commit_pc);
    check_value("commit_inst", word_t'(model.exp_inst[k]), word_t'(commit_inst));
    check_value("commit_wen", word_t'(model.exp_wen[k]), word_t'(commit_wen));
    if (model.exp_wen[k]) begin
      check_value("commit_wdest", word_t'(model.exp_wdest[k]), word_t'(commit_wdest));
      check_value("commit_wdata", model.exp_wdata[k], commit_wdata);
    end
  endtask

  // instruction port answers the fetch address
  always @(posedge clock) begin
    #(DRIVE_DELAY);
    inst = model.fetch(inst_addr);
  end

  // commit outputs are registered, so look at them mid-cycle
  always @(negedge clock) begin
    cycle_count++;
    if (cycle_count > TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles, %0d of %0d commits seen, %0d errors",
               cycle_count, next_commit, model.exp_count, errors);
      $display("tests failed");
      $finish;
    end else if (!reset) begin
      assert (commit_valid === 1'b1 || commit_wen === 1'b0) else begin
        $display("commit_wen high at time %0t without a valid commit", $time);
        errors++;
      end
      if (commit_valid === 1'b1) begin
        if (next_commit < model.exp_count) begin
          check_commit(next_commit);
          next_commit++;
        end else begin
          assert (commit_pc >= `PC_START + 4 * PROG_LEN) else begin
            $display("extra commit at time %0t for pc %h after the program ended",
                     $time, commit_pc);
            errors++;
          end
        end
      end
    end
  end

  initial begin
    errors = 0;
    next_commit = 0;
    cycle_count = 0;
    reset = 1'b1;
    inst = `NOP_INST;
    void'($urandom(SEED));
    model.build_program();
    model.run_program();
    repeat (RESET_CYCLES) @(posedge clock);
    #(DRIVE_DELAY);
    reset = 1'b0;
    wait (next_commit == model.exp_count);
    repeat (DRAIN_CYCLES) @(posedge clock);
    $display("checked %0d of %0d commits, %0d errors", next_commit, model.exp_count, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+rtl
rtl/core_pkg.sv
rtl/bypass_if.sv
rtl/pipe_stage_reg.sv
rtl/regfile.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/data_mem.sv
rtl/core_top.sv
test/core_model.sv
test/core_tb.sv
